//--- common/vdp_consts.svh
`ifndef VDP_CONSTS_SVH
`define VDP_CONSTS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// datapath sizing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define VDP_LANES       8         // longest vector the engine accepts
`define VDP_WORD_W      64
`define VDP_ADDR_W      32        // byte address on the memory port

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// host register map
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define VDP_REG_A_PTR   12'h000
`define VDP_REG_B_PTR   12'h040
`define VDP_REG_LEN     12'h080
`define VDP_REG_START   12'h0C0   // strobe only, reads back as zero
`define VDP_REG_STATUS  12'h100   // bit 0 idle, bit 1 done
`define VDP_REG_RES_PTR 12'h140

`endif

//--- common/vdp_csr_pkg.sv
package vdp_csr_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // host command port
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef enum logic {
    e_io_read  = 1'b0,
    e_io_write = 1'b1
  } io_cmd_e;

  typedef logic [11:0] io_addr_t;  // register offset within the block

endpackage

//--- common/vdp_mem_pkg.sv
`include "vdp_consts.svh"

package vdp_mem_pkg;

  typedef logic [`VDP_WORD_W-1:0] word_t;
  typedef logic [`VDP_ADDR_W-1:0] mem_addr_t;
  typedef logic [$clog2(`VDP_LANES+1)-1:0] len_t;  // holds 0 up to the lane count

  typedef enum logic {
    e_mem_load  = 1'b0,
    e_mem_store = 1'b1
  } mem_op_e;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // engine sequencing
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef enum logic [2:0] {
    e_idle,
    e_req,      // load request pending on the memory port
    e_wait,     // one request outstanding
    e_opa,
    e_opb,
    e_compute,
    e_store,    // result request pending on the memory port
    e_done
  } eng_state_e;

endpackage

//--- vdp_csr/vdp_csr.sv
`timescale 1ns/1ps
`include "vdp_consts.svh"

module vdp_csr (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   io_cmd_v_i,
  input  vdp_csr_pkg::io_cmd_e   io_cmd_i,
  input  vdp_csr_pkg::io_addr_t  io_addr_i,
  input  vdp_mem_pkg::word_t     io_data_i,
  output logic                   io_resp_v_o,
  output vdp_mem_pkg::word_t     io_data_o,
  input  logic                   busy_i,
  input  logic                   done_i,
  output vdp_mem_pkg::mem_addr_t a_ptr_o,
  output vdp_mem_pkg::mem_addr_t b_ptr_o,
  output vdp_mem_pkg::mem_addr_t res_ptr_o,
  output vdp_mem_pkg::len_t      len_o,
  output logic                   start_o
);
  import vdp_csr_pkg::*;
  import vdp_mem_pkg::*;

  logic      wr_v;
  logic      rd_v;
  mem_addr_t a_ptr_r;
  mem_addr_t b_ptr_r;
  mem_addr_t res_ptr_r;
  len_t      len_r;
  logic      done_r;
  logic      resp_v_r;
  word_t     rd_data;
  word_t     resp_data_r;

  assign wr_v = io_cmd_v_i & (io_cmd_i == e_io_write);
  assign rd_v = io_cmd_v_i & (io_cmd_i == e_io_read);

  // a start that lands while the engine runs is dropped
  assign start_o = wr_v & (io_addr_i == `VDP_REG_START) & (|io_data_i) & ~busy_i;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // programmed registers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      a_ptr_r   <= '0;
      b_ptr_r   <= '0;
      res_ptr_r <= '0;
      len_r     <= '0;
    end else if (wr_v) begin
      case (io_addr_i)
        `VDP_REG_A_PTR:   a_ptr_r   <= mem_addr_t'(io_data_i);
        `VDP_REG_B_PTR:   b_ptr_r   <= mem_addr_t'(io_data_i);
        `VDP_REG_RES_PTR: res_ptr_r <= mem_addr_t'(io_data_i);
        `VDP_REG_LEN: begin
          if (io_data_i > word_t'(`VDP_LANES)) begin
            len_r <= len_t'(`VDP_LANES);                 // clip to the buffer depth
          end else begin
            len_r <= len_t'(io_data_i);
          end
        end
        default: ;
      endcase
    end
  end

  // done stays up until the following start
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      done_r <= 1'b0;
    end else if (start_o) begin
      done_r <= 1'b0;
    end else if (done_i) begin
      done_r <= 1'b1;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read path that answers one cycle after the command
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    rd_data = '0;                                          // writes and holes return zero
    if (rd_v) begin
      case (io_addr_i)
        `VDP_REG_A_PTR:   rd_data = word_t'(a_ptr_r);
        `VDP_REG_B_PTR:   rd_data = word_t'(b_ptr_r);
        `VDP_REG_LEN:     rd_data = word_t'(len_r);
        `VDP_REG_STATUS:  rd_data = word_t'({done_r, ~busy_i});
        `VDP_REG_RES_PTR: rd_data = word_t'(res_ptr_r);
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      resp_v_r <= 1'b0;
    end else begin
      resp_v_r <= io_cmd_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    resp_data_r <= rd_data;
  end

  assign io_resp_v_o = resp_v_r;
  assign io_data_o   = resp_data_r;
  assign a_ptr_o     = a_ptr_r;
  assign b_ptr_o     = b_ptr_r;
  assign res_ptr_o   = res_ptr_r;
  assign len_o       = len_r;

  // an accepted start must actually launch the engine on the next cycle
  start_launches_job: assert property (@(posedge clk_i) disable iff (reset_i)
    start_o |=> busy_i);

endmodule

//--- vdp_engine/vdp_fetch_ctrl.sv
`timescale 1ns/1ps
`include "vdp_consts.svh"

module vdp_fetch_ctrl (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          start_i,
  input  vdp_mem_pkg::mem_addr_t        a_ptr_i,
  input  vdp_mem_pkg::mem_addr_t        b_ptr_i,
  input  vdp_mem_pkg::mem_addr_t        res_ptr_i,
  input  vdp_mem_pkg::len_t             len_i,
  input  vdp_mem_pkg::word_t            result_i,
  output logic                          mem_req_v_o,
  output vdp_mem_pkg::mem_op_e          mem_op_o,
  output vdp_mem_pkg::mem_addr_t        mem_addr_o,
  output vdp_mem_pkg::word_t            mem_wdata_o,
  input  logic                          mem_ready_i,
  input  logic                          mem_resp_v_i,
  input  vdp_mem_pkg::word_t            mem_rdata_i,
  output logic                          clear_o,
  output logic                          load_a_o,
  output logic                          load_b_o,
  output logic [$clog2(`VDP_LANES)-1:0] lane_idx_o,
  output vdp_mem_pkg::word_t            lane_data_o,
  output logic                          compute_o,
  output logic                          busy_o,
  output logic                          done_o
);
  import vdp_mem_pkg::*;

  eng_state_e state_r;
  eng_state_e state_n;
  mem_addr_t  a_ptr_r;
  mem_addr_t  b_ptr_r;
  mem_addr_t  res_ptr_r;
  mem_addr_t  base_addr;
  len_t       len_r;
  len_t       cnt_r;
  logic       op_b_r;
  mem_op_e    op_r;
  logic       launch;
  logic       last_elem;
  logic       rsp_load;

  assign launch    = (state_r == e_idle) && start_i;
  assign last_elem = (len_t'(cnt_r + 1'b1) == len_r);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // sequencing
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    state_n = state_r;
    unique case (state_r)
      e_idle: begin
        if (start_i) begin
          state_n = (len_i == '0) ? e_compute : e_req;     // empty job goes straight to store
        end
      end
      e_req: begin
        if (mem_ready_i) begin
          state_n = e_wait;
        end
      end
      e_wait: begin
        if (mem_resp_v_i) begin
          if (op_r == e_mem_store) begin
            state_n = e_done;
          end else begin
            state_n = op_b_r ? e_opb : e_opa;
          end
        end
      end
      e_opa:     state_n = e_req;
      e_opb:     state_n = last_elem ? e_compute : e_req;
      e_compute: state_n = e_store;                        // tree result registers here
      e_store: begin
        if (mem_ready_i) begin
          state_n = e_wait;
        end
      end
      e_done:    state_n = e_idle;
      default:   state_n = e_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_idle;
      cnt_r   <= '0;
      op_b_r  <= 1'b0;
      op_r    <= e_mem_load;
    end else begin
      state_r <= state_n;
      case (state_r)
        e_idle: begin
          if (start_i) begin
            cnt_r  <= '0;
            op_b_r <= 1'b0;
            op_r   <= e_mem_load;
          end
        end
        e_opa: begin
          if (last_elem) begin
            cnt_r  <= '0;                                  // A is complete so the count restarts for B
            op_b_r <= 1'b1;
          end else begin
            cnt_r <= cnt_r + 1'b1;
          end
        end
        e_opb:     cnt_r <= cnt_r + 1'b1;
        e_compute: op_r  <= e_mem_store;
        default: ;
      endcase
    end
  end

  // job parameters are frozen so host writes during a run do not disturb it
  always_ff @(posedge clk_i) begin
    if (launch) begin
      a_ptr_r   <= a_ptr_i;
      b_ptr_r   <= b_ptr_i;
      res_ptr_r <= res_ptr_i;
      len_r     <= len_i;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // memory port and lane writes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign base_addr   = op_b_r ? b_ptr_r : a_ptr_r;
  assign mem_addr_o  = (op_r == e_mem_store) ? res_ptr_r
                                             : base_addr + (mem_addr_t'(cnt_r) << 3);
  assign mem_req_v_o = ((state_r == e_req) || (state_r == e_store)) && mem_ready_i;
  assign mem_op_o    = op_r;
  assign mem_wdata_o = result_i;

  assign rsp_load    = (state_r == e_wait) && mem_resp_v_i && (op_r == e_mem_load);
  assign load_a_o    = rsp_load && !op_b_r;
  assign load_b_o    = rsp_load && op_b_r;
  assign lane_idx_o  = cnt_r[$clog2(`VDP_LANES)-1:0];
  assign lane_data_o = mem_rdata_i;

  assign clear_o     = launch;
  assign compute_o   = (state_r == e_compute);
  assign busy_o      = (state_r != e_idle);
  assign done_o      = (state_r == e_done);

  // a launched job never holds more elements than there are lanes
  len_in_range: assert property (@(posedge clk_i) disable iff (reset_i)
    launch |-> (len_i <= len_t'(`VDP_LANES)));

  // the memory side may only answer the one outstanding request
  resp_only_in_wait: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_resp_v_i |-> (state_r == e_wait));

endmodule

//--- vdp_engine/vdp_dot_unit.sv
`timescale 1ns/1ps
`include "vdp_consts.svh"

module vdp_dot_unit #(
  parameter int lanes_p = `VDP_LANES
) (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       clear_i,
  input  logic                       load_a_i,
  input  logic                       load_b_i,
  input  logic [$clog2(lanes_p)-1:0] lane_idx_i,
  input  vdp_mem_pkg::word_t         lane_data_i,
  input  logic                       compute_i,
  output vdp_mem_pkg::word_t         result_o
);
  import vdp_mem_pkg::*;

  // heap layout: node 0 is the root, the last lanes_p nodes hold the products
  localparam int nodes_lp = 2 * lanes_p - 1;

  word_t a_q [lanes_p];
  word_t b_q [lanes_p];
  wire word_t tree [nodes_lp];
  word_t result_r;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // operand buffers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk_i) begin
    if (reset_i || clear_i) begin
      for (int i = 0; i < lanes_p; i++) begin
        a_q[i] <= '0;                                      // unused lanes must add nothing
        b_q[i] <= '0;
      end
    end else begin
      if (load_a_i) begin
        a_q[lane_idx_i] <= lane_data_i;
      end
      if (load_b_i) begin
        b_q[lane_idx_i] <= lane_data_i;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // multiply and adder tree, all modulo 2^64
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  for (genvar i = 0; i < lanes_p; i++) begin : g_prod
    assign tree[lanes_p-1+i] = a_q[i] * b_q[i];
  end

  for (genvar i = 0; i < lanes_p - 1; i++) begin : g_sum
    assign tree[i] = tree[2*i+1] + tree[2*i+2];
  end

  always_ff @(posedge clk_i) begin
    if (compute_i) begin
      result_r <= tree[0];
    end
  end

  assign result_o = result_r;

endmodule

//--- rtl/vdp_top.sv
`timescale 1ns/1ps
`include "vdp_consts.svh"

module vdp_top (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   io_cmd_v_i,
  input  vdp_csr_pkg::io_cmd_e   io_cmd_i,
  input  vdp_csr_pkg::io_addr_t  io_addr_i,
  input  vdp_mem_pkg::word_t     io_data_i,
  output logic                   io_resp_v_o,
  output vdp_mem_pkg::word_t     io_data_o,
  output logic                   mem_req_v_o,
  output vdp_mem_pkg::mem_op_e   mem_op_o,
  output vdp_mem_pkg::mem_addr_t mem_addr_o,
  output vdp_mem_pkg::word_t     mem_wdata_o,
  input  logic                   mem_ready_i,
  input  logic                   mem_resp_v_i,
  input  vdp_mem_pkg::word_t     mem_rdata_i
);
  import vdp_mem_pkg::*;

  logic                          start;
  logic                          busy;
  logic                          done;
  mem_addr_t                     a_ptr;
  mem_addr_t                     b_ptr;
  mem_addr_t                     res_ptr;
  len_t                          len;
  word_t                         result;
  logic                          clear;
  logic                          load_a;
  logic                          load_b;
  logic [$clog2(`VDP_LANES)-1:0] lane_idx;
  word_t                         lane_data;
  logic                          compute;

  vdp_csr csr_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .io_cmd_v_i  (io_cmd_v_i),
    .io_cmd_i    (io_cmd_i),
    .io_addr_i   (io_addr_i),
    .io_data_i   (io_data_i),
    .io_resp_v_o (io_resp_v_o),
    .io_data_o   (io_data_o),
    .busy_i      (busy),
    .done_i      (done),
    .a_ptr_o     (a_ptr),
    .b_ptr_o     (b_ptr),
    .res_ptr_o   (res_ptr),
    .len_o       (len),
    .start_o     (start)
  );

  vdp_fetch_ctrl fetch_ctrl_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .start_i      (start),
    .a_ptr_i      (a_ptr),
    .b_ptr_i      (b_ptr),
    .res_ptr_i    (res_ptr),
    .len_i        (len),
    .result_i     (result),
    .mem_req_v_o  (mem_req_v_o),
    .mem_op_o     (mem_op_o),
    .mem_addr_o   (mem_addr_o),
    .mem_wdata_o  (mem_wdata_o),
    .mem_ready_i  (mem_ready_i),
    .mem_resp_v_i (mem_resp_v_i),
    .mem_rdata_i  (mem_rdata_i),
    .clear_o      (clear),
    .load_a_o     (load_a),
    .load_b_o     (load_b),
    .lane_idx_o   (lane_idx),
    .lane_data_o  (lane_data),
    .compute_o    (compute),
    .busy_o       (busy),
    .done_o       (done)
  );

  vdp_dot_unit #(
    .lanes_p (`VDP_LANES)
  ) dot_unit_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .clear_i     (clear),
    .load_a_i    (load_a),
    .load_b_i    (load_b),
    .lane_idx_i  (lane_idx),
    .lane_data_i (lane_data),
    .compute_i   (compute),
    .result_o    (result)
  );

endmodule

//--- verification/vdp_tb_mem.sv
`timescale 1ns/1ps

module vdp_tb_mem #(
  parameter int seed_p  = 12388,
  parameter int words_p = 1024
) (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   mem_req_v_i,
  input  vdp_mem_pkg::mem_op_e   mem_op_i,
  input  vdp_mem_pkg::mem_addr_t mem_addr_i,
  input  vdp_mem_pkg::word_t     mem_wdata_i,
  output logic                   mem_ready_o,
  output logic                   mem_resp_v_o,
  output vdp_mem_pkg::word_t     mem_rdata_o,
  output int                     store_cnt_o
);
  import vdp_mem_pkg::*;

  localparam int drive_delay_lp = 5;

  word_t     words [words_p];
  integer    seed;
  logic      pend_v;
  mem_op_e   pend_op;
  mem_addr_t pend_addr;
  word_t     pend_wdata;
  int        delay;

  initial begin
    seed         = seed_p;
    pend_v       = 1'b0;
    mem_ready_o  = 1'b0;
    mem_resp_v_o = 1'b0;
    mem_rdata_o  = '0;
    store_cnt_o  = 0;
    for (int i = 0; i < words_p; i++) begin
      words[i] = {~mem_addr_t'(i * 8), mem_addr_t'(i * 8)};  // fill follows the byte address
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // one request at a time, answered after 0 to 3 idle cycles
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(posedge clk_i) begin
    if (reset_i) begin
      pend_v = 1'b0;
      #drive_delay_lp;
      mem_ready_o  = 1'b0;
      mem_resp_v_o = 1'b0;
    end else begin
      if (mem_req_v_i && mem_ready_o) begin
        pend_v     = 1'b1;
        pend_op    = mem_op_i;
        pend_addr  = mem_addr_i;
        pend_wdata = mem_wdata_i;
        delay      = $unsigned($random(seed)) % 4;
      end
      #drive_delay_lp;
      mem_resp_v_o = 1'b0;
      if (pend_v && delay == 0) begin
        mem_resp_v_o = 1'b1;
        pend_v       = 1'b0;
        if (pend_op == e_mem_store) begin
          words[pend_addr[$clog2(words_p)+2:3]] = pend_wdata;
          store_cnt_o = store_cnt_o + 1;
          mem_rdata_o = '0;
        end else begin
          mem_rdata_o = words[pend_addr[$clog2(words_p)+2:3]];
        end
      end else if (pend_v) begin
        delay = delay - 1;
      end
      mem_ready_o = ($unsigned($random(seed)) % 4) != 0;  // stall about one cycle in four
    end
  end

endmodule

//--- verification/vdp_tb.sv
`timescale 1ns/1ps
`include "vdp_consts.svh"

module vdp_tb;
  import vdp_csr_pkg::*;
  import vdp_mem_pkg::*;

  localparam int clk_period_lp  = 100;
  localparam int drive_delay_lp = 5;
  localparam int seed_lp        = 12388;
  localparam int mem_words_lp   = 1024;
  localparam int max_polls_lp   = 400;
  localparam int num_jobs_lp    = 20;

  logic      clk_i;
  logic      reset_i;
  logic      io_cmd_v_i;
  io_cmd_e   io_cmd_i;
  io_addr_t  io_addr_i;
  word_t     io_data_i;
  logic      io_resp_v_o;
  word_t     io_data_o;
  logic      mem_req_v_o;
  mem_op_e   mem_op_o;
  mem_addr_t mem_addr_o;
  word_t     mem_wdata_o;
  logic      mem_ready_i;
  logic      mem_resp_v_i;
  word_t     mem_rdata_i;
  int        store_cnt;
  integer    seed;

  vdp_top vdp_top_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .io_cmd_v_i   (io_cmd_v_i),
    .io_cmd_i     (io_cmd_i),
    .io_addr_i    (io_addr_i),
    .io_data_i    (io_data_i),
    .io_resp_v_o  (io_resp_v_o),
    .io_data_o    (io_data_o),
    .mem_req_v_o  (mem_req_v_o),
    .mem_op_o     (mem_op_o),
    .mem_addr_o   (mem_addr_o),
    .mem_wdata_o  (mem_wdata_o),
    .mem_ready_i  (mem_ready_i),
    .mem_resp_v_i (mem_resp_v_i),
    .mem_rdata_i  (mem_rdata_i)
  );

  vdp_tb_mem #(
    .seed_p  (seed_lp),
    .words_p (mem_words_lp)
  ) mem_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .mem_req_v_i  (mem_req_v_o),
    .mem_op_i     (mem_op_o),
    .mem_addr_i   (mem_addr_o),
    .mem_wdata_i  (mem_wdata_o),
    .mem_ready_o  (mem_ready_i),
    .mem_resp_v_o (mem_resp_v_i),
    .mem_rdata_o  (mem_rdata_i),
    .store_cnt_o  (store_cnt)
  );

  initial begin
    clk_i = 1'b0;
    forever #(clk_period_lp / 2) clk_i = ~clk_i;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // failure reporting and compares
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      fail_run($sformatf("MISMATCH %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_status(input string name, input logic [1:0] exp, input logic [1:0] act);
    if (act !== exp) begin
      fail_run($sformatf("MISMATCH %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  task automatic check_mem(input string name, input word_t exp, input mem_addr_t addr);
    word_t act;
    act = mem_i.words[mem_index(addr)];
    if (act !== exp) begin
      fail_run($sformatf("MISMATCH %s at %h: expected %h, actual %h", name, addr, exp, act));
    end
  endtask

  function automatic int mem_index(input mem_addr_t addr);
    return int'(addr[$clog2(mem_words_lp)+2:3]);
  endfunction

  function automatic word_t rand_word();
    return {$random(seed), $random(seed)};
  endfunction

  // word aligned pointer with room for a full vector after it
  function automatic mem_addr_t rand_ptr(input mem_addr_t base);
    return base + mem_addr_t'(($unsigned($random(seed)) % 248) * 8);
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // host register access that starts 5 ns after a rising edge
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic host_cmd(input io_cmd_e cmd, input io_addr_t addr, input word_t wdata,
                          output word_t rdata);
    if (io_resp_v_o !== 1'b0) begin
      fail_run("response strobe is high with no command outstanding");
    end
    io_cmd_v_i = 1'b1;
    io_cmd_i   = cmd;
    io_addr_i  = addr;
    io_data_i  = wdata;
    @(posedge clk_i);
    #drive_delay_lp;
    io_cmd_v_i = 1'b0;
    if (io_resp_v_o !== 1'b1) begin
      fail_run("no response one cycle after the command");
    end
    rdata = io_data_o;
    @(posedge clk_i);
    #drive_delay_lp;
    if (io_resp_v_o !== 1'b0) begin
      fail_run("response strobe lasted more than one cycle");
    end
  endtask

  task automatic reg_write(input io_addr_t addr, input word_t data);
    word_t rd;
    host_cmd(e_io_write, addr, data, rd);
    check_word("write response data", '0, rd);
  endtask

  task automatic reg_read(input io_addr_t addr, output word_t data);
    host_cmd(e_io_read, addr, '0, data);
  endtask

  task automatic read_status(output logic [1:0] st);
    word_t rd;
    reg_read(`VDP_REG_STATUS, rd);
    check_word("status upper bits", '0, rd >> 2);
    st = rd[1:0];
  endtask

  task automatic check_ptr_reg(input string name, input io_addr_t off);
    word_t val;
    word_t rd;
    val = rand_word();
    reg_write(off, val);
    reg_read(off, rd);
    check_word(name, word_t'(mem_addr_t'(val)), rd);          // only 32 address bits kept
  endtask

  task automatic check_len(input word_t val);
    word_t rd;
    reg_write(`VDP_REG_LEN, val);
    reg_read(`VDP_REG_LEN, rd);
    check_word($sformatf("len readback of %0h", val),
               (val > `VDP_LANES) ? word_t'(`VDP_LANES) : val, rd);
  endtask

  task automatic check_reads_zero(input string name, input io_addr_t off);
    word_t rd;
    reg_read(off, rd);
    check_word(name, '0, rd);
  endtask

  // polls status until the engine is idle with done set
  task automatic wait_job_done(input string name);
    logic [1:0] st;
    int         polls;
    polls = 0;
    read_status(st);
    while (st != 2'b11) begin
      polls++;
      if (polls > max_polls_lp) begin
        fail_run($sformatf("%s did not finish within %0d status polls", name, max_polls_lp));
      end
      read_status(st);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // one dot-product job against the reference sum
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic run_job(input string name, input mem_addr_t a_ptr, input mem_addr_t b_ptr,
                         input mem_addr_t res_ptr, input int len, input bit restart_busy);
    word_t      op_a;
    word_t      op_b;
    word_t      expected;
    word_t      start_val;
    logic [1:0] st;
    int         stores_before;
    expected = '0;
    for (int i = 0; i < len; i++) begin
      op_a = rand_word();
      op_b = rand_word();
      mem_i.words[mem_index(a_ptr + mem_addr_t'(i * 8))] = op_a;
      mem_i.words[mem_index(b_ptr + mem_addr_t'(i * 8))] = op_b;
      expected = expected + op_a * op_b;                      // wraps at 64 bits
    end
    mem_i.words[mem_index(res_ptr)] = ~expected;             // stale value a missed store leaves
    stores_before = store_cnt;
    reg_write(`VDP_REG_A_PTR, word_t'(a_ptr));
    reg_write(`VDP_REG_B_PTR, word_t'(b_ptr));
    reg_write(`VDP_REG_RES_PTR, word_t'(res_ptr));
    reg_write(`VDP_REG_LEN, word_t'(len));
    start_val = rand_word();
    if (start_val == '0) begin
      start_val = word_t'(1);
    end
    reg_write(`VDP_REG_START, start_val);
    read_status(st);
    check_status({name, " status after start"}, 2'b00, st);
    if (restart_busy) begin
      reg_write(`VDP_REG_LEN, word_t'(1));
      reg_write(`VDP_REG_START, word_t'(1));
      read_status(st);
      check_status({name, " status after second start"}, 2'b00, st);
    end
    wait_job_done(name);
    check_mem({name, " result"}, expected, res_ptr);
    check_word({name, " store count"}, word_t'(stores_before + 1), word_t'(store_cnt));
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // test sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    logic [1:0] st;
    word_t      rd_before;
    word_t      rd_after;
    mem_addr_t  a_ptr;
    mem_addr_t  b_ptr;
    mem_addr_t  res_ptr;
    int         len;
    seed       = seed_lp;
    reset_i    = 1'b1;
    io_cmd_v_i = 1'b0;
    io_cmd_i   = e_io_read;
    io_addr_i  = '0;
    io_data_i  = '0;
    repeat (3) @(posedge clk_i);
    #drive_delay_lp;
    reset_i = 1'b0;

    if (mem_req_v_o !== 1'b0) begin
      fail_run("memory request is high right after reset");
    end
    read_status(st);
    check_status("status after reset", 2'b01, st);

    check_ptr_reg("a_ptr readback", `VDP_REG_A_PTR);
    check_ptr_reg("b_ptr readback", `VDP_REG_B_PTR);
    check_ptr_reg("res_ptr readback", `VDP_REG_RES_PTR);
    check_len(word_t'(1));
    check_len(word_t'(5));
    check_len(word_t'(0));
    check_len(word_t'(8));
    check_len(word_t'(9));
    check_len(word_t'(15));
    check_len(rand_word() | word_t'(16));
    check_reads_zero("start register read", `VDP_REG_START);
    check_reads_zero("unmapped read at 020", 12'h020);
    check_reads_zero("unmapped read at 180", 12'h180);
    check_reads_zero("unmapped read at ff8", 12'hFF8);
    reg_read(`VDP_REG_A_PTR, rd_before);
    reg_write(12'h180, rand_word());
    check_reads_zero("unmapped read after write", 12'h180);
    reg_read(`VDP_REG_A_PTR, rd_after);
    check_word("a_ptr after unmapped write", rd_before, rd_after);
    reg_write(`VDP_REG_START, '0);                            // zero start must not launch
    read_status(st);
    check_status("status after zero start", 2'b01, st);

    for (int j = 0; j < num_jobs_lp; j++) begin
      a_ptr   = rand_ptr(32'h0000_0000);
      b_ptr   = rand_ptr(32'h0000_0800);
      res_ptr = rand_ptr(32'h0000_1000);
      len     = 1 + int'($unsigned($random(seed)) % `VDP_LANES);
      run_job($sformatf("job %0d", j), a_ptr, b_ptr, res_ptr, len, 1'b0);
    end

    run_job("empty job", rand_ptr(32'h0000_0000), rand_ptr(32'h0000_0800),
            rand_ptr(32'h0000_1000), 0, 1'b0);
    run_job("restart while busy", rand_ptr(32'h0000_0000), rand_ptr(32'h0000_0800),
            rand_ptr(32'h0000_1000), `VDP_LANES, 1'b1);

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

//--- vdp_top.f
+incdir+common
common/vdp_csr_pkg.sv
common/vdp_mem_pkg.sv
vdp_csr/vdp_csr.sv
vdp_engine/vdp_fetch_ctrl.sv
vdp_engine/vdp_dot_unit.sv
rtl/vdp_top.sv
verification/vdp_tb_mem.sv
verification/vdp_tb.sv

//--- Bender.yml
package:
  name: vdp

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/vdp_csr_pkg.sv
      - common/vdp_mem_pkg.sv
      - vdp_csr/vdp_csr.sv
      - vdp_engine/vdp_fetch_ctrl.sv
      - vdp_engine/vdp_dot_unit.sv
      - rtl/vdp_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - verification/vdp_tb_mem.sv
      - verification/vdp_tb.sv
